// ==== cache_req_pkg.sv ====
// cache requester types

package cache_req_pkg;

`include "wb_master_params.svh"

    // which cache an access belongs to
    // the tag rides with the request and comes back on every response
    typedef enum logic {
        SRC_ICACHE = 1'b0,
        SRC_DCACHE = 1'b1
    } req_src_e;

    // ========================================
    // request and response
    // ========================================

    // one access as the arbiter hands it to the bus side
    // burst means a wrapping line fill, and is never set with write
    // for a write the low address bits already follow the byte enables
    typedef struct packed {
        req_src_e              src;
        logic                  burst;
        logic                  write;
        logic [`WB_SEL_W-1:0]  be;
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_DATA_W-1:0] wdata;
    } cache_req_t;

    // one acked beat going back to its requester
    // valid is high for a single cycle per beat, last marks the final one
    // rdata is the bus read data and means nothing for a write
    typedef struct packed {
        req_src_e              src;
        logic                  valid;
        logic                  last;
        logic [`WB_DATA_W-1:0] rdata;
    } cache_resp_t;

endpackage

// ==== request_arbiter.sv ====
// cache request arbiter

`timescale 1ns/100ps
`include "wb_master_params.svh"

module request_arbiter
    import cache_req_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  quick_n_reset,
    // instruction cache port
    input  logic                  i_icache_req,
    input  logic                  i_icache_qword,
    input  logic [`WB_ADDR_W-1:0] i_icache_address,
    output logic [`WB_DATA_W-1:0] o_icache_read_data,
    output logic                  o_icache_ready,
    // data cache port
    input  logic                  i_dcache_req,
    input  logic                  i_dcache_qword,
    input  logic                  i_dcache_write,
    input  logic [`WB_DATA_W-1:0] i_dcache_write_data,
    input  logic [`WB_SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [`WB_ADDR_W-1:0] i_dcache_address,
    output logic [`WB_DATA_W-1:0] o_dcache_read_data,
    output logic                  o_dcache_ready,
    // request slot side
    output logic                  o_push,
    output cache_req_t            o_req,
    input  logic                  i_full,
    // completed beats from the sequencer
    input  cache_resp_t           i_resp
);

    // a source is busy from its push until its last beat comes back
    logic       icache_busy_r;
    logic       dcache_busy_r;
    // set for the one cycle after a last beat, while req is still falling
    logic       icache_done_r;
    logic       dcache_done_r;
    logic       icache_pend;
    logic       dcache_pend;
    logic       icache_resp;
    logic       dcache_resp;
    logic [1:0] low_bits;

    // ========================================
    // request selection
    // ========================================

    assign icache_pend = i_icache_req && !icache_busy_r && !icache_done_r;
    assign dcache_pend = i_dcache_req && !dcache_busy_r && !dcache_done_r;

    // the slot takes a new entry only while it is empty
    assign o_push = (icache_pend || dcache_pend) && !i_full;

    // byte and half-word writes put the lane number on the low address bits
    // every other pattern, and every read, leaves them at zero
    always_comb
    begin
        low_bits = 2'd0;
        if (i_dcache_write)
        begin
            case (i_dcache_byte_enable)
                4'b0010: low_bits = 2'd1;
                4'b0100: low_bits = 2'd2;
                4'b1000: low_bits = 2'd3;
                4'b1100: low_bits = 2'd2;
                default: low_bits = 2'd0;
            endcase
        end
    end

    // dcache wins whenever it has something new to send
    always_comb
    begin
        if (dcache_pend)
        begin
            o_req.src   = SRC_DCACHE;
            o_req.burst = i_dcache_qword && !i_dcache_write;
            o_req.write = i_dcache_write;
            o_req.be    = i_dcache_byte_enable;
            o_req.addr  = {i_dcache_address[`WB_ADDR_W-1:2], low_bits};
            o_req.wdata = i_dcache_write_data;
        end
        else
        begin
            // icache only ever reads, so all lanes are on
            o_req.src   = SRC_ICACHE;
            o_req.burst = i_icache_qword;
            o_req.write = 1'b0;
            o_req.be    = '1;
            o_req.addr  = {i_icache_address[`WB_ADDR_W-1:2], 2'b00};
            o_req.wdata = '0;
        end
    end

    // ========================================
    // completion routing
    // ========================================

    assign icache_resp = i_resp.valid && (i_resp.src == SRC_ICACHE);
    assign dcache_resp = i_resp.valid && (i_resp.src == SRC_DCACHE);

    assign o_icache_ready     = icache_resp;
    assign o_dcache_ready     = dcache_resp;
    assign o_icache_read_data = i_resp.rdata;
    assign o_dcache_read_data = i_resp.rdata;

    // a push never meets a last beat of the same source, since push needs !busy
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            icache_busy_r <= 1'b0;
            dcache_busy_r <= 1'b0;
            icache_done_r <= 1'b0;
            dcache_done_r <= 1'b0;
        end
        else
        begin
            icache_done_r <= icache_resp && i_resp.last;
            dcache_done_r <= dcache_resp && i_resp.last;
            if (o_push && (o_req.src == SRC_ICACHE))
                icache_busy_r <= 1'b1;
            else if (icache_resp && i_resp.last)
                icache_busy_r <= 1'b0;
            if (o_push && (o_req.src == SRC_DCACHE))
                dcache_busy_r <= 1'b1;
            else if (dcache_resp && i_resp.last)
                dcache_busy_r <= 1'b0;
        end
    end

endmodule

// ==== request_slot.sv ====
// one-entry request slot

`timescale 1ns/100ps

module request_slot
    import cache_req_pkg::*;
(
    input  logic       i_clk,
    input  logic       quick_n_reset,
    // producer side
    input  logic       i_push,
    input  cache_req_t i_req,
    output logic       o_full,
    // consumer side
    output logic       o_valid,
    output cache_req_t o_req,
    input  logic       i_take
);

    logic       valid_r;
    cache_req_t req_r;

    // with a single entry, full and valid are the same flag
    // the producer waits on it, the consumer starts a bus cycle on it
    assign o_full  = valid_r;
    assign o_valid = valid_r;
    assign o_req   = req_r;

    // ========================================
    // occupancy
    // ========================================

    // a push in the same cycle as a take refills the entry, so push wins
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
            valid_r <= 1'b0;
        else if (i_push)
            valid_r <= 1'b1;
        else if (i_take)
            valid_r <= 1'b0;
    end

    // ========================================
    // stored request
    // ========================================

    // payload only loads on a push and holds while the entry waits
    always_ff @(posedge i_clk)
    begin
        if (i_push)
            req_r <= i_req;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the wishbone master testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sim.f \
    --top-module tb_wb_master -Mdir obj_dir -o tb_wb_master
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_wb_master > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== sim.f ====
+incdir+.
wb_bus_pkg.sv
cache_req_pkg.sv
request_arbiter.sv
request_slot.sv
wb_sequencer.sv
wb_master_top.sv
wb_slave_model.sv
tb_wb_master.sv

// ==== tb_wb_master.sv ====
// wishbone master testbench

`timescale 1ns/100ps
`include "wb_master_params.svh"

module tb_wb_master;

    // worst test length is near 750 cycles, so this leaves about 4x headroom
    localparam int          CYCLE_LIMIT = 3000;
    localparam logic [31:0] FILL        = 32'h5a3c_96e1;

    logic        i_clk;
    logic        quick_n_reset;
    logic        i_icache_req;
    logic        i_icache_qword;
    logic [31:0] i_icache_address;
    logic [31:0] o_icache_read_data;
    logic        o_icache_ready;
    logic        i_dcache_req;
    logic        i_dcache_qword;
    logic        i_dcache_write;
    logic [31:0] i_dcache_write_data;
    logic [3:0]  i_dcache_byte_enable;
    logic [31:0] i_dcache_address;
    logic [31:0] o_dcache_read_data;
    logic        o_dcache_ready;
    logic [31:0] o_wb_adr;
    logic [3:0]  o_wb_sel;
    logic        o_wb_we;
    logic [31:0] o_wb_dat;
    logic        o_wb_cyc;
    logic        o_wb_stb;
    logic [31:0] i_wb_dat;
    logic        i_wb_ack;

    // shadow of the slave memory, kept by the reference side only
    logic [31:0] shadow [0:255];
    integer      seed;
    // random stimulus for the mixed run, one entry per access
    logic [31:0] i_rand [0:19];
    logic [31:0] d_rand [0:19];
    logic [31:0] d_wdata [0:19];
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    // per port, beats expected so far, beats seen so far and where this access began
    string       i_name = "none";
    string       d_name = "none";
    int          i_total_want = 0;
    int          i_total_got = 0;
    int          i_base = 0;
    int          i_first = 0;
    int          d_total_want = 0;
    int          d_total_got = 0;
    int          d_base = 0;
    int          d_last = 0;

    wb_master_top u_dut (.*);

    wb_slave_model #(.STALL_SEED(61), .FILL_PATTERN(FILL)) u_slave (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_wb_adr      (o_wb_adr),
        .i_wb_sel      (o_wb_sel),
        .i_wb_we       (o_wb_we),
        .i_wb_dat      (o_wb_dat),
        .i_wb_cyc      (o_wb_cyc),
        .i_wb_stb      (o_wb_stb),
        .o_wb_dat      (i_wb_dat),
        .o_wb_ack      (i_wb_ack)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // ========================================
    // reference model
    // ========================================

    // the expected word is whatever the shadow holds at that word address
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return shadow[addr[9:2]];
    endfunction

    // beat n of a line fill, counted from the requested word and wrapping in 16 bytes
    function automatic logic [31:0] beat_addr(input logic [31:0] addr, input int beat);
        logic [1:0] word;
        word = addr[3:2] + 2'(beat);
        return {addr[31:4], word, 2'b00};
    endfunction

    // single bytes and aligned half-words put their lowest lane on the low address bits
    // any other enable pattern leaves them at zero
    function automatic logic [1:0] lane_offset(input logic [3:0] be);
        logic [1:0] low;
        low = 2'd0;
        for (int b = 3; b >= 0; b--)
            if (be[b])
                low = 2'(b);
        if ($countones(be) == 1 || be == 4'b0011 || be == 4'b1100)
            return low;
        return 2'd0;
    endfunction

    task automatic merge_write(input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] data);
        for (int b = 0; b < 4; b++)
            if (be[b])
                shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    // ========================================
    // requester drivers
    // ========================================

    // req and fields stay stable until the last ready, then drop one cycle later
    task automatic icache_access(input string name, input logic burst,
                                 input logic [31:0] addr);
        int beats;
        beats = burst ? `WB_BURST_LEN : 1;
        @(posedge i_clk);
        #1;
        i_name = name;
        i_base = i_total_got;
        i_total_want = i_total_want + beats;
        i_icache_req = 1'b1;
        i_icache_qword = burst;
        i_icache_address = addr;
        do
            @(posedge i_clk);
        while (i_total_got < i_base + beats);
        #1;
        i_icache_req = 1'b0;
    endtask

    task automatic dcache_access(input string name, input logic burst, input logic write,
                                 input logic [3:0] be, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        int beats;
        beats = (burst && !write) ? `WB_BURST_LEN : 1;
        @(posedge i_clk);
        #1;
        d_name = name;
        d_base = d_total_got;
        d_total_want = d_total_want + beats;
        i_dcache_req = 1'b1;
        i_dcache_qword = burst && !write;
        i_dcache_write = write;
        i_dcache_byte_enable = be;
        i_dcache_address = addr;
        i_dcache_write_data = wdata;
        do
            @(posedge i_clk);
        while (d_total_got < d_base + beats);
        #1;
        i_dcache_req = 1'b0;
    endtask

    // ========================================
    // compare process
    // ========================================

    // outputs settle well before the falling edge
    always @(negedge i_clk)
    begin
        if (o_icache_ready)
        begin
            if (i_total_got >= i_total_want)
            begin
                errors++;
                $display("unexpected ready pulse on the icache port after %s", i_name);
            end
            else
                check_value(i_name, expected_word(beat_addr(i_icache_address,
                            i_total_got - i_base)), o_icache_read_data);
            if (i_total_got == i_base)
                i_first = cycle;
            i_total_got++;
        end
        if (o_dcache_ready)
        begin
            if (d_total_got >= d_total_want)
            begin
                errors++;
                $display("unexpected ready pulse on the dcache port after %s", d_name);
            end
            else if (i_dcache_write)
                merge_write(i_dcache_address, i_dcache_byte_enable, i_dcache_write_data);
            else
                check_value(d_name, expected_word(beat_addr(i_dcache_address,
                            d_total_got - d_base)), o_dcache_read_data);
            d_last = cycle;
            d_total_got++;
        end
        // the written beat carries the enables, the lane offset and the write data
        if (o_wb_cyc && o_wb_we && i_wb_ack)
        begin
            check_value({d_name, " sel"}, 32'(i_dcache_byte_enable), 32'(o_wb_sel));
            check_value({d_name, " adr"}, {i_dcache_address[31:2],
                        lane_offset(i_dcache_byte_enable)}, o_wb_adr);
            check_value({d_name, " dat"}, i_dcache_write_data, o_wb_dat);
        end
    end

    always @(posedge i_clk)
    begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, a request never finished", cycle);
            $display("checks: %0d  errors: %0d", checks, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ========================================
    // test sequence
    // ========================================

    initial
    begin
        seed = 61;
        for (int i = 0; i < 256; i++)
            shadow[i] = 32'(i) ^ FILL;
        quick_n_reset = 1'b0;
        i_icache_req = 1'b0;
        i_icache_qword = 1'b0;
        i_icache_address = '0;
        i_dcache_req = 1'b0;
        i_dcache_qword = 1'b0;
        i_dcache_write = 1'b0;
        i_dcache_write_data = '0;
        i_dcache_byte_enable = '0;
        i_dcache_address = '0;
        repeat (4) @(posedge i_clk);
        #1;
        quick_n_reset = 1'b1;
        check_value("reset cyc", 32'd0, 32'(o_wb_cyc));
        check_value("reset stb", 32'd0, 32'(o_wb_stb));
        check_value("reset we", 32'd0, 32'(o_wb_we));

        icache_access("icache single", 1'b0, 32'h0000_0044);
        icache_access("icache burst wrap", 1'b1, 32'h0000_0108);
        dcache_access("dcache burst", 1'b1, 1'b0, 4'hf, 32'h0000_023c, '0);
        dcache_access("dcache byte write", 1'b0, 1'b1, 4'b0100, 32'h0000_0250, 32'hcafe_f00d);
        dcache_access("dcache byte read", 1'b0, 1'b0, 4'hf, 32'h0000_0250, '0);
        dcache_access("dcache half write", 1'b0, 1'b1, 4'b1100, 32'h0000_0254, 32'h1234_5678);
        dcache_access("dcache half read", 1'b0, 1'b0, 4'hf, 32'h0000_0254, '0);

        // both rise on the same edge, dcache must finish before icache starts
        fork
            icache_access("same cycle icache", 1'b1, 32'h0000_0184);
            dcache_access("same cycle dcache", 1'b1, 1'b0, 4'hf, 32'h0000_02c8, '0);
        join
        check_value("dcache before icache", 32'd1, 32'(d_last < i_first));

        for (int n = 0; n < 20; n++)
        begin
            i_rand[n] = $random(seed);
            d_rand[n] = $random(seed);
            d_wdata[n] = $random(seed);
        end

        // icache reads the low half and dcache owns the upper half
        fork
            for (int n = 0; n < 20; n++)
            begin
                icache_access("random icache", i_rand[n][0], i_rand[n] & 32'h1fc);
            end
            for (int n = 0; n < 20; n++)
            begin
                dcache_access("random dcache", d_rand[n][0], d_rand[n][1], d_rand[n][7:4],
                              32'h200 | (d_rand[n] & 32'h1fc), d_wdata[n]);
            end
        join

        repeat (4) @(posedge i_clk);
        check_value("icache pulse count", i_total_want, i_total_got);
        check_value("dcache pulse count", d_total_want, d_total_got);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== wb_bus_pkg.sv ====
// wishbone bus types

package wb_bus_pkg;

`include "wb_master_params.svh"

    // ========================================
    // address views
    // ========================================

    // an address split into line, word within the line and byte in the word
    // the line field takes whatever is left above the word index
    typedef struct packed {
        logic [`WB_ADDR_W-`WB_WORD_IDX_W-3:0] line;
        logic [`WB_WORD_IDX_W-1:0]            word;
        logic [1:0]                           byte_off;
    } wb_addr_fields_t;

    // the same 32-bit word seen flat or split into fields
    // the field view lets a burst step only the word index, so the
    // address wraps inside its line and never crosses into the next one
    typedef union packed {
        logic [`WB_ADDR_W-1:0] flat;
        wb_addr_fields_t       f;
    } wb_addr_u;

    // ========================================
    // bus command
    // ========================================

    // everything the master drives on the bus for one transfer
    // cyc and stb are kept apart since they are control, not payload
    typedef struct packed {
        wb_addr_u              adr;
        logic [`WB_SEL_W-1:0]  sel;
        logic                  we;
        logic [`WB_DATA_W-1:0] dat;
    } wb_cmd_t;

endpackage

// ==== wb_master_params.svh ====
// wishbone master parameters

`ifndef WB_MASTER_PARAMS_SVH
`define WB_MASTER_PARAMS_SVH

// ========================================
// bus widths
// ========================================

// byte address width on the wishbone side
`define WB_ADDR_W 32

// data word width, one 32-bit word per beat
`define WB_DATA_W 32

// one select line per byte lane
`define WB_SEL_W 4

// ========================================
// cache line geometry
// ========================================

// beats in a line fill, a 16-byte line of 32-bit words
`define WB_BURST_LEN 4

// bits that pick a word inside the line, address bits 3:2
`define WB_WORD_IDX_W 2

`endif

// ==== wb_master_top.sv ====
// wishbone master top level

`timescale 1ns/100ps
`include "wb_master_params.svh"

module wb_master_top
    import cache_req_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  quick_n_reset,
    // instruction cache port
    input  logic                  i_icache_req,
    input  logic                  i_icache_qword,
    input  logic [`WB_ADDR_W-1:0] i_icache_address,
    output logic [`WB_DATA_W-1:0] o_icache_read_data,
    output logic                  o_icache_ready,
    // data cache port
    input  logic                  i_dcache_req,
    input  logic                  i_dcache_qword,
    input  logic                  i_dcache_write,
    input  logic [`WB_DATA_W-1:0] i_dcache_write_data,
    input  logic [`WB_SEL_W-1:0]  i_dcache_byte_enable,
    input  logic [`WB_ADDR_W-1:0] i_dcache_address,
    output logic [`WB_DATA_W-1:0] o_dcache_read_data,
    output logic                  o_dcache_ready,
    // wishbone bus
    output logic [`WB_ADDR_W-1:0] o_wb_adr,
    output logic [`WB_SEL_W-1:0]  o_wb_sel,
    output logic                  o_wb_we,
    output logic [`WB_DATA_W-1:0] o_wb_dat,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    input  logic [`WB_DATA_W-1:0] i_wb_dat,
    input  logic                  i_wb_ack
);

    // arbiter into the slot
    logic        push;
    logic        slot_full;
    cache_req_t  arb_req;
    // slot into the sequencer
    logic        slot_valid;
    logic        take;
    cache_req_t  slot_req;
    // beats back from the bus
    cache_resp_t resp;

    request_arbiter u_arbiter (
        .i_clk                (i_clk),
        .quick_n_reset        (quick_n_reset),
        .i_icache_req         (i_icache_req),
        .i_icache_qword       (i_icache_qword),
        .i_icache_address     (i_icache_address),
        .o_icache_read_data   (o_icache_read_data),
        .o_icache_ready       (o_icache_ready),
        .i_dcache_req         (i_dcache_req),
        .i_dcache_qword       (i_dcache_qword),
        .i_dcache_write       (i_dcache_write),
        .i_dcache_write_data  (i_dcache_write_data),
        .i_dcache_byte_enable (i_dcache_byte_enable),
        .i_dcache_address     (i_dcache_address),
        .o_dcache_read_data   (o_dcache_read_data),
        .o_dcache_ready       (o_dcache_ready),
        .o_push               (push),
        .o_req                (arb_req),
        .i_full               (slot_full),
        .i_resp               (resp)
    );

    request_slot u_slot (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_push        (push),
        .i_req         (arb_req),
        .o_full        (slot_full),
        .o_valid       (slot_valid),
        .o_req         (slot_req),
        .i_take        (take)
    );

    wb_sequencer u_sequencer (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_valid       (slot_valid),
        .i_req         (slot_req),
        .o_take        (take),
        .o_resp        (resp),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_we       (o_wb_we),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack)
    );

endmodule

// ==== wb_sequencer.sv ====
// wishbone bus sequencer

`timescale 1ns/100ps
`include "wb_master_params.svh"

module wb_sequencer
    import wb_bus_pkg::*, cache_req_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  quick_n_reset,
    // request slot side
    input  logic                  i_valid,
    input  cache_req_t            i_req,
    output logic                  o_take,
    // completed beats back to the arbiter
    output cache_resp_t           o_resp,
    // wishbone master side
    output logic [`WB_ADDR_W-1:0] o_wb_adr,
    output logic [`WB_SEL_W-1:0]  o_wb_sel,
    output logic                  o_wb_we,
    output logic [`WB_DATA_W-1:0] o_wb_dat,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    input  logic [`WB_DATA_W-1:0] i_wb_dat,
    input  logic                  i_wb_ack
);

    // burst covers every beat but the last one of a line fill
    // wait-final covers the last beat of a burst and every single access
    typedef enum logic [1:0] {
        SEQ_IDLE       = 2'd0,
        SEQ_BURST      = 2'd1,
        SEQ_WAIT_FINAL = 2'd2
    } seq_state_e;

    // beat count at which the next ack is the second to last
    localparam logic [`WB_WORD_IDX_W-1:0] LAST_BURST_CNT = `WB_WORD_IDX_W'(`WB_BURST_LEN - 2);

    seq_state_e                state_r;
    wb_cmd_t                   cmd_r;
    req_src_e                  src_r;
    logic                      active_r;
    logic [`WB_WORD_IDX_W-1:0] beat_cnt_r;

    // ========================================
    // bus outputs
    // ========================================

    // no bus locking here, so cyc and stb always move together
    assign o_wb_cyc = active_r;
    assign o_wb_stb = active_r;
    assign o_wb_adr = cmd_r.adr.flat;
    assign o_wb_sel = cmd_r.sel;
    assign o_wb_we  = cmd_r.we;
    assign o_wb_dat = cmd_r.dat;

    // a new command is only taken with the bus idle
    assign o_take = (state_r == SEQ_IDLE) && i_valid;

    // one response per ack, in the ack cycle, data straight from the bus
    assign o_resp.src   = src_r;
    assign o_resp.valid = active_r && i_wb_ack;
    assign o_resp.last  = (state_r == SEQ_WAIT_FINAL);
    assign o_resp.rdata = i_wb_dat;

    // ========================================
    // state machine
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r    <= SEQ_IDLE;
            active_r   <= 1'b0;
            src_r      <= SRC_ICACHE;
            beat_cnt_r <= '0;
            cmd_r.we   <= 1'b0;
        end
        else
        begin
            case (state_r)
                SEQ_IDLE:
                begin
                    if (i_valid)
                    begin
                        // reads drive every lane, writes drive their enables
                        cmd_r.adr.flat <= i_req.addr;
                        cmd_r.sel      <= i_req.write ? i_req.be : '1;
                        cmd_r.we       <= i_req.write;
                        cmd_r.dat      <= i_req.wdata;
                        src_r          <= i_req.src;
                        active_r       <= 1'b1;
                        beat_cnt_r     <= '0;
                        state_r        <= i_req.burst ? SEQ_BURST : SEQ_WAIT_FINAL;
                    end
                end

                SEQ_BURST:
                begin
                    if (i_wb_ack)
                    begin
                        // only the word index steps, so 2,3 wraps to 0,1
                        cmd_r.adr.f.word <= cmd_r.adr.f.word + `WB_WORD_IDX_W'(1);
                        beat_cnt_r       <= beat_cnt_r + `WB_WORD_IDX_W'(1);
                        if (beat_cnt_r == LAST_BURST_CNT)
                            state_r <= SEQ_WAIT_FINAL;
                    end
                end

                SEQ_WAIT_FINAL:
                begin
                    // release the bus on the edge after the final ack
                    if (i_wb_ack)
                    begin
                        active_r <= 1'b0;
                        cmd_r.we <= 1'b0;
                        state_r  <= SEQ_IDLE;
                    end
                end

                default:
                begin
                    active_r <= 1'b0;
                    state_r  <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== wb_slave_model.sv ====
// wishbone memory slave model

`timescale 1ns/100ps
`include "wb_master_params.svh"

module wb_slave_model
#(
    parameter int          STALL_SEED   = 61,
    parameter logic [31:0] FILL_PATTERN = 32'h5a3c_96e1
)
(
    input  logic                  i_clk,
    input  logic                  quick_n_reset,
    input  logic [`WB_ADDR_W-1:0] i_wb_adr,
    input  logic [`WB_SEL_W-1:0]  i_wb_sel,
    input  logic                  i_wb_we,
    input  logic [`WB_DATA_W-1:0] i_wb_dat,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    output logic [`WB_DATA_W-1:0] o_wb_dat,
    output logic                  o_wb_ack
);

    // 1 KB of memory, so only address bits 9:2 pick a word
    logic [`WB_DATA_W-1:0] mem [0:255];
    logic [7:0]            idx;
    logic [1:0]            wait_cnt;
    integer                seed;
    integer                draw;

    assign idx = i_wb_adr[9:2];

    // every word starts as its word address XOR the fill pattern
    initial
    begin
        seed = STALL_SEED;
        for (int i = 0; i < 256; i++)
            mem[i] = 32'(i) ^ FILL_PATTERN;
    end

    // ========================================
    // ack with random stalls
    // ========================================

    // ack is registered and lasts one cycle, then a new stall of 0 to 3 is drawn
    always @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
            wait_cnt <= 2'd0;
        end
        else if (o_wb_ack)
        begin
            draw = $random(seed);
            o_wb_ack <= 1'b0;
            wait_cnt <= draw[1:0];
        end
        else if (i_wb_cyc && i_wb_stb)
        begin
            if (wait_cnt != 2'd0)
                wait_cnt <= wait_cnt - 2'd1;
            else
            begin
                o_wb_ack <= 1'b1;
                o_wb_dat <= mem[idx];
                // a write only touches the lanes that sel enables
                if (i_wb_we)
                begin
                    for (int b = 0; b < `WB_SEL_W; b++)
                        if (i_wb_sel[b])
                            mem[idx][8*b +: 8] = i_wb_dat[8*b +: 8];
                end
            end
        end
    end

endmodule
